//--- files.f
design/hps_pkg.sv
design/video_pkg.sv
design/hps_cmd_decoder.sv
design/video_mode_select.sv
design/button_debounce.sv
design/sync_polarity_fix.sv
design/sys_top.sv
verification/tb_clock.sv
verification/tb_sys_top.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sys_top -f files.f -o tb_sys_top
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build ended with status $status"
	exit $status
fi

./obj_dir/tb_sys_top
status=$?
if [ $status -ne 0 ]; then
	echo "Testbench run ended with status $status"
	exit $status
fi

exit 0

//--- verification/tb_sys_top.sv
// Table-driven testbench for the board housekeeping top level
`default_nettype none

module tb_sys_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned NUM_TESTS = 27;
	localparam int unsigned LIMIT     = NUM_TESTS * 400;
	// Long high and short low sync waveforms
	localparam int VS_HIGH = 30;
	localparam int VS_LOW  = 6;
	localparam int HS_HIGH = 9;
	localparam int HS_LOW  = 3;

	typedef enum logic [2:0] {OP_STATUS, OP_FRAME, OP_RESET, OP_BUTTON, OP_LED, OP_SYNC} op_t;

	typedef struct packed {
		op_t              kind;
		logic [3:0]       n_words;
		logic [10:0][15:0] words;
		logic [95:0]      exp_timing;
		logic [31:0]      exp_val;
		logic [2:0][15:0] arg;
	} test_entry_t;

	logic                     FPGA_CLK2_50;
	logic                     resetd;
	logic [31:0]              gp_out;
	logic [31:0]              gp_in;
	logic                     btn_user;
	logic                     btn_osd;
	logic [1:0]               key;
	logic                     core_led_user;
	logic [1:0]               core_led_power;
	logic [1:0]               core_led_disk;
	logic                     vs_emu;
	logic                     hs_emu;
	logic                     led_user;
	logic                     led_hdd;
	logic                     led_power;
	logic [7:0]               led;
	logic                     vga_hs;
	logic                     vga_vs;
	video_pkg::video_timing_t timing;
	logic                     dvi_mode;
	logic                     audio_96k;
	logic                     ypbpr_en;
	logic                     reset_req;

	test_entry_t tests [NUM_TESTS];
	string       names [NUM_TESTS];
	int          n_built = 0;
	logic [95:0] custom_exp;
	int unsigned cycle_cnt = 0;

	tb_clock u_clock (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd)
	);

	sys_top #(
		.DEB_DIV    (3),
		.SYNC_CNT_W (16)
	) u_sys_top (.*);

	// ==================================================
	// Helpers
	// ==================================================
	task automatic step();
		@(posedge FPGA_CLK2_50);
		#1;
	endtask

	task automatic check(input string nm, input logic [95:0] exp, input logic [95:0] act);
		assert (act === exp) else begin
			$display("FAILED %s: expected %0h, actual %0h", nm, exp, act);
			$display("Simulation failed");
			$fatal(1, "Mismatch in %s", nm);
		end
	endtask

	// Ack reaches gp_in bit 17 a few cycles after io_clk moves
	task automatic wait_ack(input logic lvl);
		step();
		while (gp_in[17] !== lvl) begin
			step();
		end
	endtask

	function automatic logic [95:0] mode_timing(input logic [2:0] m);
		case (m)
			3'd1: return {12'd1024, 12'd24, 12'd136, 12'd160, 12'd768, 12'd3, 12'd6, 12'd29};
			3'd2: return {12'd720, 12'd16, 12'd62, 12'd60, 12'd480, 12'd9, 12'd6, 12'd30};
			3'd3: return {12'd720, 12'd12, 12'd64, 12'd68, 12'd576, 12'd5, 12'd5, 12'd39};
			3'd4: return {12'd1280, 12'd48, 12'd112, 12'd248, 12'd1024, 12'd1, 12'd3, 12'd38};
			3'd5: return {12'd800, 12'd40, 12'd128, 12'd88, 12'd600, 12'd1, 12'd4, 12'd23};
			3'd6: return {12'd640, 12'd16, 12'd96, 12'd48, 12'd480, 12'd10, 12'd2, 12'd33};
			3'd7: return {12'd1280, 12'd440, 12'd40, 12'd220, 12'd720, 12'd5, 12'd5, 12'd20};
			default: return {12'd1280, 12'd110, 12'd40, 12'd220, 12'd720, 12'd5, 12'd5, 12'd20};
		endcase
	endfunction

	function automatic logic [15:0] cfg_din(input logic [2:0] res, input logic dvi,
			input logic a96, input logic ypbpr, input logic csync);
		logic [15:0] d;
		d       = '0;
		d[10:8] = res;
		d[7]    = dvi;
		d[6]    = a96;
		d[5]    = ypbpr;
		d[3]    = csync;
		return d;
	endfunction

	task automatic add_entry(input string nm, input op_t kind, input int a0, input int a1,
			input int a2, input logic [31:0] exp_val);
		names[n_built]         = nm;
		tests[n_built]         = '0;
		tests[n_built].kind    = kind;
		tests[n_built].arg[0]  = 16'(a0);
		tests[n_built].arg[1]  = 16'(a1);
		tests[n_built].arg[2]  = 16'(a2);
		tests[n_built].exp_val = exp_val;
		n_built++;
	endtask

	// Command word then one data word
	task automatic push_frame(input string nm, input logic [15:0] cmd, input logic [15:0] data,
			input logic [95:0] t, input logic [2:0] c);
		add_entry(nm, OP_FRAME, 0, 0, 0, {29'd0, c});
		tests[n_built-1].n_words    = 4'd2;
		tests[n_built-1].words[0]   = cmd;
		tests[n_built-1].words[1]   = data;
		tests[n_built-1].exp_timing = t;
	endtask

	// ==================================================
	// Stimulus table
	// ==================================================
	task automatic build_table();
		logic [15:0] rw [10];
		logic [2:0]  m;
		for (int k = 0; k < 10; k++) begin
			rw[k] = 16'($urandom);
		end
		custom_exp = {rw[0][11:0], rw[1][11:0], rw[2][11:0], rw[3][11:0],
		              rw[4][11:0], rw[5][11:0], rw[6][11:0], rw[7][11:0]};

		add_entry("status_word", OP_STATUS, 0, 0, 0, 32'd0);
		push_frame("custom_default", 16'h0001, cfg_din(3'd0, 1'b0, 1'b0, 1'b0, 1'b0),
		           mode_timing(3'd0), 3'b000);
		// Eight timing words plus two that must be ignored
		push_frame("custom_load", 16'h0020, rw[0], custom_exp, 3'b000);
		tests[n_built-1].n_words = 4'd11;
		for (int k = 0; k < 10; k++) begin
			tests[n_built-1].words[k+1] = rw[k];
		end
		for (int i = 1; i <= 7; i++) begin
			m = 3'(i);
			push_frame($sformatf("mode_%0d", i), 16'h0001, cfg_din(m, m[0], m[1], ~m[0], 1'b0),
			           mode_timing(m), {m[0], m[1], ~m[0]});
		end
		push_frame("custom_back", 16'h0001, cfg_din(3'd0, 1'b1, 1'b1, 1'b1, 1'b0),
		           custom_exp, 3'b111);

		add_entry("reset_set", OP_RESET, 1, 0, 0, 32'd1);
		add_entry("reset_stray_two", OP_RESET, 2, 0, 0, 32'd1);
		add_entry("reset_code_zero", OP_RESET, 0, 0, 0, 32'd1);
		add_entry("reset_clear", OP_RESET, 2, 0, 0, 32'd0);

		// Select, press cycles, release cycles, expected {user, osd}
		add_entry("user_press", OP_BUTTON, 1, 40, 0, 32'd2);
		add_entry("user_release", OP_BUTTON, 1, 0, 40, 32'd0);
		add_entry("osd_press", OP_BUTTON, 0, 40, 0, 32'd1);
		add_entry("osd_release", OP_BUTTON, 0, 0, 40, 32'd0);
		add_entry("user_glitch", OP_BUTTON, 1, 1 + int'($urandom % 28), 40, 32'd0);

		for (int k = 0; k < 4; k++) begin
			add_entry($sformatf("leds_%0d", k), OP_LED, int'($urandom % 64), 0, 0, 32'd0);
		end

		add_entry("sync_separate", OP_SYNC, 0, 0, 0, 32'd0);
		push_frame("csync_on", 16'h0001, cfg_din(3'd0, 1'b0, 1'b0, 1'b0, 1'b1),
		           custom_exp, 3'b000);
		add_entry("sync_composite", OP_SYNC, 1, 0, 0, 32'd0);
	endtask

	// ==================================================
	// Operations
	// ==================================================
	task automatic show_status_word(input string nm);
		gp_out[31] = 1'b0;
		step();
		check(nm, 96'(32'h5CA6_23A4), 96'(gp_in));
		gp_out[31] = 1'b1;
		step();
		check(nm, 96'(3'b001), 96'({gp_in[31], gp_in[19:18]}));
	endtask

	task automatic send_frame(input test_entry_t e, input string nm);
		for (int k = 0; k < int'(e.n_words); k++) begin
			gp_out[15:0] = e.words[k];
			gp_out[20]   = 1'b1;
			gp_out[17]   = 1'b1;
			wait_ack(1'b1);
			gp_out[17] = 1'b0;
			wait_ack(1'b0);
		end
		gp_out[20] = 1'b0;
		repeat (10) step();
		check(nm, e.exp_timing, 96'(timing));
		check(nm, 96'(e.exp_val[2:0]), 96'({dvi_mode, audio_96k, ypbpr_en}));
	endtask

	task automatic apply_reset_code(input test_entry_t e, input string nm);
		gp_out[31:30] = e.arg[0][1:0];
		repeat (4) step();
		check(nm, 96'(e.exp_val[0]), 96'(reset_req));
	endtask

	task automatic hold_button(input test_entry_t e, input string nm);
		if (e.arg[0][0]) begin
			btn_user = 1'b0;
		end else begin
			btn_osd = 1'b0;
		end
		repeat (e.arg[1]) step();
		if (e.arg[2] != 16'd0) begin
			// A short press must not have moved the level
			if (e.arg[1] != 16'd0) begin
				check(nm, 96'(e.exp_val[1:0]), 96'({gp_in[30], gp_in[29]}));
			end
			btn_user = 1'b1;
			btn_osd  = 1'b1;
			repeat (e.arg[2]) step();
		end
		check(nm, 96'(e.exp_val[1:0]), 96'({gp_in[30], gp_in[29]}));
	endtask

	task automatic set_leds(input test_entry_t e, input string nm);
		logic       p;
		logic       d;
		logic       u;
		logic [7:0] bar;
		{core_led_user, core_led_power, core_led_disk, gp_out[29]} = e.arg[0][5:0];
		step();
		p = (core_led_power == 2'b10);
		if (core_led_disk[1]) begin
			d = (core_led_disk[0] == 1'b0);
		end else begin
			d = ({core_led_disk[0], gp_out[29]} == 2'b00);
		end
		u = (core_led_user == 1'b0);
		// Bar lamps are lit low
		bar    = 8'h00;
		bar[4] = !p;
		bar[2] = !d;
		bar[0] = !u;
		check(nm, 96'({p, d, u, bar}), 96'({led_power, led_hdd, led_user, led}));
	endtask

	// Four VS periods with checks over the last two
	task automatic drive_sync(input test_entry_t e, input string nm);
		int   vs_per;
		int   hs_per;
		logic vs_n;
		logic hs_n;
		logic exp_vs;
		logic exp_hs;
		vs_per = VS_HIGH + VS_LOW;
		hs_per = HS_HIGH + HS_LOW;
		for (int t = 0; t < 4 * vs_per; t++) begin
			vs_emu = (t % vs_per) < VS_HIGH;
			hs_emu = (t % hs_per) < HS_HIGH;
			step();
			if (t >= 2 * vs_per) begin
				// Normalized sync is high during the short phase
				vs_n = (VS_HIGH > VS_LOW) ? ~vs_emu : vs_emu;
				hs_n = (HS_HIGH > HS_LOW) ? ~hs_emu : hs_emu;
				if (e.arg[0][0]) begin
					exp_vs = 1'b1;
					exp_hs = ~(vs_n ^ hs_n);
				end else begin
					exp_vs = ~vs_n;
					exp_hs = ~hs_n;
				end
				check(nm, 96'({exp_vs, exp_hs}), 96'({vga_vs, vga_hs}));
			end
		end
	endtask

	// ==================================================
	// Run control
	// ==================================================
	always @(posedge FPGA_CLK2_50) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) begin
			$display("Timeout after %0d cycles, the test table did not complete", LIMIT);
			$display("Simulation failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	initial begin
		void'($urandom(32'h4356_b351));
		// Idle host word keeps bit 31 high so gp_in shows status
		gp_out         = 32'h8000_0000;
		btn_user       = 1'b1;
		btn_osd        = 1'b1;
		key            = 2'b11;
		core_led_user  = 1'b0;
		core_led_power = 2'b00;
		core_led_disk  = 2'b00;
		vs_emu         = 1'b1;
		hs_emu         = 1'b1;
		build_table();
		@(negedge resetd);
		step();
		for (int i = 0; i < int'(NUM_TESTS); i++) begin
			case (tests[i].kind)
				OP_STATUS: show_status_word(names[i]);
				OP_FRAME:  send_frame(tests[i], names[i]);
				OP_RESET:  apply_reset_code(tests[i], names[i]);
				OP_BUTTON: hold_button(tests[i], names[i]);
				OP_LED:    set_leds(tests[i], names[i]);
				OP_SYNC:   drive_sync(tests[i], names[i]);
				default: begin
					$display("Table entry %0d has an unknown operation", i);
					$display("Simulation failed");
					$fatal(1, "Bad table entry");
				end
			endcase
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
// Testbench clock and reset source, 4 ns clock with reset held for four cycles
`default_nettype none

module tb_clock #(
	parameter int unsigned HALF_NS      = 2,
	parameter int unsigned RESET_CYCLES = 4
) (
	output logic FPGA_CLK2_50,
	output logic resetd
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		FPGA_CLK2_50 = 1'b0;
		forever #(HALF_NS) FPGA_CLK2_50 = ~FPGA_CLK2_50;
	end

	// Release lines up with the input drive offset
	initial begin
		resetd = 1'b1;
		repeat (RESET_CYCLES) @(posedge FPGA_CLK2_50);
		#1;
		resetd = 1'b0;
	end

endmodule

`default_nettype wire

//--- design/sys_top.sv
// Board housekeeping top with host link, reset request, buttons, LEDs and VGA sync
`default_nettype none

module sys_top #(
	parameter int unsigned DEB_DIV    = 100000,
	parameter int unsigned SYNC_CNT_W = 16
) (
	input  wire logic                      FPGA_CLK2_50,
	input  wire logic                      resetd,
	input  wire logic [31:0]               gp_out,
	output      logic [31:0]               gp_in,
	input  wire logic                      btn_user,
	input  wire logic                      btn_osd,
	input  wire logic [1:0]                key,
	input  wire logic                      core_led_user,
	input  wire logic [1:0]                core_led_power,
	input  wire logic [1:0]                core_led_disk,
	input  wire logic                      vs_emu,
	input  wire logic                      hs_emu,
	output      logic                      led_user,
	output      logic                      led_hdd,
	output      logic                      led_power,
	output      logic [7:0]                led,
	output      logic                      vga_hs,
	output      logic                      vga_vs,
	output      video_pkg::video_timing_t  timing,
	output      logic                      dvi_mode,
	output      logic                      audio_96k,
	output      logic                      ypbpr_en,
	output      logic                      reset_req
);

	logic [31:0]       gp_outd;
	logic [31:0]       gp_outr;
	hps_pkg::host_io_t host;
	hps_pkg::cfg_t     cfg;
	logic              io_ack;
	logic [1:0]        rst_prev;
	logic [31:0]       status_word;
	video_pkg::video_timing_t custom_timing;
	logic [1:0]        btn_pressed;
	logic [1:0]        btn_level;
	logic              led_p;
	logic              led_d;
	logic              led_u;
	logic              vs;
	logic              hs;

	// ==================================================
	// Host link
	// ==================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			gp_outd <= '0;
			gp_outr <= '0;
		end else begin
			gp_outd <= gp_out;
			gp_outr <= gp_outd;
		end
	end

	assign host = '{
		din:      gp_outr[hps_pkg::DIN_W-1:0],
		io_clk:   gp_outr[hps_pkg::IO_CLK_BIT],
		io_fpga:  gp_outr[hps_pkg::IO_FPGA_BIT],
		io_osd:   gp_outr[hps_pkg::IO_OSD_BIT],
		io_uio:   gp_outr[hps_pkg::IO_UIO_BIT],
		disk_act: gp_outr[hps_pkg::DISK_ACT_BIT],
		rst_ctl:  gp_outr[hps_pkg::RST_CTL_LSB +: 2]
	};

	always_comb begin
		status_word = '0;
		status_word[hps_pkg::STAT_USER_BIT]    = btn_level[1];
		status_word[hps_pkg::STAT_OSD_BIT]     = btn_level[0];
		status_word[hps_pkg::STAT_VER_LSB +: 2] = hps_pkg::IO_VER;
		status_word[hps_pkg::STAT_ACK_BIT]     = io_ack;
	end

	// Magic tells the host the fabric is configured
	assign gp_in = gp_out[hps_pkg::HOST_SEL_BIT] ? status_word : hps_pkg::CORE_MAGIC;

	hps_cmd_decoder u_cmd_decoder (
		.FPGA_CLK2_50  (FPGA_CLK2_50),
		.resetd        (resetd),
		.host          (host),
		.io_ack        (io_ack),
		.cfg           (cfg),
		.custom_timing (custom_timing)
	);

	video_mode_select u_mode_select (
		.FPGA_CLK2_50  (FPGA_CLK2_50),
		.resetd        (resetd),
		.hdmi_res      (cfg.hdmi_res),
		.custom_timing (custom_timing),
		.timing        (timing)
	);

	assign dvi_mode  = cfg.dvi_mode;
	assign audio_96k = cfg.audio_96k;
	assign ypbpr_en  = cfg.ypbpr_en;

	// ==================================================
	// Reset request
	// ==================================================
	// Clear needs code 0 then code 2, so a stray 2 does nothing
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rst_prev  <= '0;
			reset_req <= 1'b0;
		end else begin
			rst_prev <= host.rst_ctl;
			if (host.rst_ctl == 2'd1) begin
				reset_req <= 1'b1;
			end
			if (host.rst_ctl == 2'd2 && rst_prev == 2'd0) begin
				reset_req <= 1'b0;
			end
		end
	end

	// Buttons and keys are active low
	assign btn_pressed = {~(btn_user & key[1]), ~(btn_osd & key[0])};

	button_debounce #(
		.DEB_DIV (DEB_DIV)
	) u_debounce (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.pressed      (btn_pressed),
		.level        (btn_level)
	);

	// LEDs
	assign led_p = core_led_power[1] & ~core_led_power[0];
	assign led_d = core_led_disk[1] ? ~core_led_disk[0]
	                                : ~(core_led_disk[0] | gp_out[hps_pkg::DISK_ACT_BIT]);
	assign led_u = ~core_led_user;

	assign led_power = led_p;
	assign led_hdd   = led_d;
	assign led_user  = led_u;
	assign led       = {3'b000, ~led_p, 1'b0, ~led_d, 1'b0, ~led_u};

	// ==================================================
	// VGA sync
	// ==================================================
	sync_polarity_fix #(
		.SYNC_CNT_W (SYNC_CNT_W)
	) u_sync_v (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (vs_emu),
		.sync_out     (vs)
	);

	sync_polarity_fix #(
		.SYNC_CNT_W (SYNC_CNT_W)
	) u_sync_h (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_in      (hs_emu),
		.sync_out     (hs)
	);

	// Composite sync rides on HS, VS held inactive
	assign vga_vs = cfg.csync ? 1'b1 : ~vs;
	assign vga_hs = cfg.csync ? ~(vs ^ hs) : ~hs;

endmodule

`default_nettype wire

//--- design/sync_polarity_fix.sv
// Sync polarity fixer that flips the input so the short phase is always the high pulse
`default_nettype none

module sync_polarity_fix #(
	parameter int unsigned SYNC_CNT_W = 16
) (
	input  wire logic FPGA_CLK2_50,
	input  wire logic resetd,
	input  wire logic sync_in,
	output      logic sync_out
);

	logic                  s1;
	logic                  s2;
	logic [SYNC_CNT_W-1:0] phase_cnt;
	logic [SYNC_CNT_W-1:0] low_len;
	logic [SYNC_CNT_W-1:0] high_len;
	logic                  pol;

	assign sync_out = sync_in ^ pol;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			s1        <= 1'b0;
			s2        <= 1'b0;
			phase_cnt <= '0;
			low_len   <= '0;
			high_len  <= '0;
			pol       <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;

			// Rising edge ends a low phase, falling edge a high phase
			if (!s2 && s1) begin
				low_len <= phase_cnt;
			end
			if (s2 && !s1) begin
				high_len <= phase_cnt;
			end

			if (s2 != s1) begin
				phase_cnt <= '0;
			end else if (phase_cnt != '1) begin
				phase_cnt <= phase_cnt + 1'b1;
			end

			pol <= (high_len > low_len);
		end
	end

endmodule

`default_nettype wire

//--- design/button_debounce.sv
// Button debouncer that samples on a slow tick and needs eight equal samples to change
`default_nettype none

module button_debounce #(
	parameter int unsigned DEB_DIV = 100000
) (
	input  wire logic       FPGA_CLK2_50,
	input  wire logic       resetd,
	input  wire logic [1:0] pressed,
	output      logic [1:0] level
);

	localparam int unsigned DIV_W = $clog2(DEB_DIV + 1);

	logic [DIV_W-1:0]  div_cnt;
	logic              tick;
	logic [1:0][7:0]   hist;

	// Tick once every DEB_DIV+1 cycles
	assign tick = (div_cnt == DIV_W'(DEB_DIV));

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			div_cnt <= '0;
		end else if (tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// Index 1 is the user button, index 0 the OSD button
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			hist  <= '0;
			level <= '0;
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				hist[i] <= {hist[i][6:0], pressed[i]};
				if (&hist[i]) begin
					level[i] <= 1'b1;
				end
				if (hist[i] == 8'h00) begin
					level[i] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/video_mode_select.sv
// Video mode selector that picks a fixed mode or the custom timing and registers it
`default_nettype none

module video_mode_select (
	input  wire logic                            FPGA_CLK2_50,
	input  wire logic                            resetd,
	input  wire logic [hps_pkg::HDMI_RES_W-1:0]  hdmi_res,
	input  wire video_pkg::video_timing_t        custom_timing,
	output      video_pkg::video_timing_t        timing
);

	video_pkg::video_timing_t timing_next;

	// Mode 0 is the host-loaded custom timing
	always_comb begin
		if (hdmi_res == '0) begin
			timing_next = custom_timing;
		end else begin
			timing_next = video_pkg::MODE_TABLE[hdmi_res];
		end
	end

	// Reset value matches mode 0 with default custom timing
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			timing <= video_pkg::CUSTOM_DEFAULT;
		end else begin
			timing <= timing_next;
		end
	end

endmodule

`default_nettype wire

//--- design/hps_cmd_decoder.sv
// Host command decoder that makes strobe and ack and parses config and custom timing frames
`default_nettype none

module hps_cmd_decoder (
	input  wire logic                      FPGA_CLK2_50,
	input  wire logic                      resetd,
	input  wire hps_pkg::host_io_t         host,
	output      logic                      io_ack,
	output      hps_pkg::cfg_t             cfg,
	output      video_pkg::video_timing_t  custom_timing
);

	logic              rack;
	logic              io_strobe;
	logic              has_cmd;
	hps_pkg::cmd_t     cmd;
	logic [3:0]        word_cnt;
	hps_pkg::cfg_t     cfg_word;
	video_pkg::tim_t   timing_word;

	// ==================================================
	// Strobe and ack
	// ==================================================
	// One pulse per io_clk rising level
	assign io_strobe = host.io_clk & ~rack;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rack   <= 1'b0;
			io_ack <= 1'b0;
		end else begin
			rack   <= host.io_clk;
			io_ack <= rack;
		end
	end

	// Field views of the current data word
	assign cfg_word = '{
		hdmi_res:  host.din[hps_pkg::CFG_RES_LSB +: hps_pkg::HDMI_RES_W],
		dvi_mode:  host.din[hps_pkg::CFG_DVI_BIT],
		audio_96k: host.din[hps_pkg::CFG_A96_BIT],
		ypbpr_en:  host.din[hps_pkg::CFG_YPBPR_BIT],
		csync:     host.din[hps_pkg::CFG_CSYNC_BIT]
	};

	assign timing_word = host.din[video_pkg::TIM_W-1:0];

	// ==================================================
	// Command frame
	// ==================================================
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			has_cmd       <= 1'b0;
			cmd           <= '0;
			word_cnt      <= '0;
			cfg           <= '0;
			custom_timing <= video_pkg::CUSTOM_DEFAULT;
		end else if (!host.io_uio) begin
			has_cmd <= 1'b0;
		end else if (io_strobe) begin
			if (!has_cmd) begin
				// First word of a frame is the command
				has_cmd  <= 1'b1;
				cmd      <= host.din[7:0];
				word_cnt <= '0;
			end else begin
				case (cmd)
					hps_pkg::CMD_CFG: begin
						cfg <= cfg_word;
					end
					hps_pkg::CMD_TIMING: begin
						// Words past the eighth carried PLL data, dropped here
						if (word_cnt < video_pkg::TIMING_WORDS) begin
							word_cnt <= word_cnt + 4'd1;
							case (word_cnt)
								4'd0: custom_timing.width  <= timing_word;
								4'd1: custom_timing.hfp    <= timing_word;
								4'd2: custom_timing.hs     <= timing_word;
								4'd3: custom_timing.hbp    <= timing_word;
								4'd4: custom_timing.height <= timing_word;
								4'd5: custom_timing.vfp    <= timing_word;
								4'd6: custom_timing.vs     <= timing_word;
								4'd7: custom_timing.vbp    <= timing_word;
								default: begin
								end
							endcase
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- design/video_pkg.sv
// Video timing package with the timing record and the fixed output mode table
`default_nettype none

package video_pkg;

	localparam int unsigned TIM_W        = 12;
	// Words carried by a custom timing command
	localparam int unsigned TIMING_WORDS = 8;

	typedef logic [TIM_W-1:0] tim_t;

	typedef struct packed {
		tim_t width;
		tim_t hfp;
		tim_t hs;
		tim_t hbp;
		tim_t height;
		tim_t vfp;
		tim_t vs;
		tim_t vbp;
	} video_timing_t;

	// ==================================================
	// Fixed modes 1 to 7
	// ==================================================
	localparam video_timing_t MODE_TABLE [1:7] = '{
		// 1024x768 VESA, 65 MHz
		'{12'd1024, 12'd24,  12'd136, 12'd160, 12'd768,  12'd3,  12'd6, 12'd29},
		// 720x480 CEA, 27 MHz
		'{12'd720,  12'd16,  12'd62,  12'd60,  12'd480,  12'd9,  12'd6, 12'd30},
		// 720x576 CEA, 27 MHz
		'{12'd720,  12'd12,  12'd64,  12'd68,  12'd576,  12'd5,  12'd5, 12'd39},
		// 1280x1024 VESA, 108 MHz
		'{12'd1280, 12'd48,  12'd112, 12'd248, 12'd1024, 12'd1,  12'd3, 12'd38},
		// 800x600 VESA, 40 MHz
		'{12'd800,  12'd40,  12'd128, 12'd88,  12'd600,  12'd1,  12'd4, 12'd23},
		// 640x480, 25.175 MHz
		'{12'd640,  12'd16,  12'd96,  12'd48,  12'd480,  12'd10, 12'd2, 12'd33},
		// 1280x720 with wide front porch
		'{12'd1280, 12'd440, 12'd40,  12'd220, 12'd720,  12'd5,  12'd5, 12'd20}
	};

	// 1280x720 CEA, 74.25 MHz
	localparam video_timing_t CUSTOM_DEFAULT = '{
		width:  12'd1280,
		hfp:    12'd110,
		hs:     12'd40,
		hbp:    12'd220,
		height: 12'd720,
		vfp:    12'd5,
		vs:     12'd5,
		vbp:    12'd20
	};

endpackage

`default_nettype wire

//--- design/hps_pkg.sv
// Host link package with the decoded host word, config fields, command codes and core magic
`default_nettype none

package hps_pkg;

	// ==================================================
	// Host word bit positions (gp_out)
	// ==================================================
	localparam int unsigned DIN_W        = 16;
	localparam int unsigned IO_CLK_BIT   = 17;
	localparam int unsigned IO_FPGA_BIT  = 18;
	localparam int unsigned IO_OSD_BIT   = 19;
	localparam int unsigned IO_UIO_BIT   = 20;
	localparam int unsigned DISK_ACT_BIT = 29;
	localparam int unsigned RST_CTL_LSB  = 30;
	// Host reads magic while this bit is low
	localparam int unsigned HOST_SEL_BIT = 31;

	// Status word bit positions (gp_in)
	localparam int unsigned STAT_USER_BIT = 30;
	localparam int unsigned STAT_OSD_BIT  = 29;
	localparam int unsigned STAT_VER_LSB  = 18;
	localparam int unsigned STAT_ACK_BIT  = 17;

	// Config word bit positions (command 1 data)
	localparam int unsigned HDMI_RES_W      = 3;
	localparam int unsigned CFG_RES_LSB     = 8;
	localparam int unsigned CFG_DVI_BIT     = 7;
	localparam int unsigned CFG_A96_BIT     = 6;
	localparam int unsigned CFG_YPBPR_BIT   = 5;
	localparam int unsigned CFG_CSYNC_BIT   = 3;

	typedef struct packed {
		logic [DIN_W-1:0] din;
		logic             io_clk;
		logic             io_fpga;
		logic             io_osd;
		logic             io_uio;
		logic             disk_act;
		logic [1:0]       rst_ctl;
	} host_io_t;

	typedef struct packed {
		logic [HDMI_RES_W-1:0] hdmi_res;
		logic                  dvi_mode;
		logic                  audio_96k;
		logic                  ypbpr_en;
		logic                  csync;
	} cfg_t;

	typedef logic [7:0] cmd_t;

	localparam cmd_t CMD_CFG    = 8'h01;
	localparam cmd_t CMD_TIMING = 8'h20;

	// Generic core type in the low byte
	localparam logic [31:0] CORE_MAGIC = 32'h5CA6_23A4;
	localparam logic [1:0]  IO_VER     = 2'd1;

endpackage

`default_nettype wire
